//--- project.f
+incdir+verilog
verilog/dctPkg.sv
verilog/dctBlockBuffer.sv
verilog/dctMacUnit.sv
verilog/dctSequencer.sv
verilog/dctTop.sv
tb/dct_props.sv
tb/dctTb.sv

//--- tb/dctTb.sv
`timescale 1ns/1ps
`include "dct_cfg.svh"

module dctTb;

   localparam int blkN      = `DCT_BLOCK_N;
   localparam int words     = blkN * blkN;
   localparam int waitLimit = 2000;             // cycles, compute takes about 1040

   logic         clk;
   logic         reset;
   logic         inValid;
   logic         inReady;
   dctPkg::dataT inData;
   logic         outValid;
   logic         outReady;
   dctPkg::dataT outData;

   dctPkg::dataT inBlk [words];                 // block under test
   dctPkg::dataT expBlk [words];                // expected results, row-major
   int           dataErrors;
   int           flagErrors;
   int           timeoutErrors;
   bit           aborted;                       // set on a timeout, skips the rest

   dctTop dctTop_inst
   (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .inReady  (inReady),
      .inData   (inData),
      .outValid (outValid),
      .outReady (outReady),
      .outData  (outData)
   );

   bind dctTop dctProps propsInst
   (
      .clk      (clk),
      .reset    (reset),
      .inReady  (inReady),
      .outValid (outValid),
      .outReady (outReady),
      .outData  (outData)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;                    // 8 ns period
   end

   task automatic checkData(input dctPkg::dataT expected, input dctPkg::dataT actual,
                            input string name);
      if (actual !== expected)
      begin
         dataErrors++;
         $display("FAIL %s expected %0d actual %0d", name, expected, actual);
      end
   endtask

   task automatic checkFlag(input logic expected, input logic actual, input string name);
      if (actual !== expected)
      begin
         flagErrors++;
         $display("FAIL %s expected %0b actual %0b", name, expected, actual);
      end
   endtask

   task automatic timedOut(input string what);
      timeoutErrors++;
      aborted = 1'b1;
      $display("timeout: no handshake on %s within %0d cycles", what, waitLimit);
   endtask

   // both passes straight from the formulas, 32-bit wrap
   task automatic runModel();
      dctPkg::dataT temp [words];
      dctPkg::dataT sum;
      for (int j = 0; j < blkN; j++)
      begin
         for (int i = 0; i < blkN; i++)
         begin
            sum = '0;
            for (int k = 0; k < blkN; k++)
            begin
               sum = sum + inBlk[j*blkN+k] * dctPkg::dataT'(dctPkg::cosTable[i][k]);
            end
            temp[j*blkN+i] = sum;               // temp[j][i]
         end
      end
      for (int j = 0; j < blkN; j++)
      begin
         for (int i = 0; i < blkN; i++)
         begin
            sum = '0;
            for (int k = 0; k < blkN; k++)
            begin
               sum = sum + temp[k*blkN+i] * dctPkg::dataT'(dctPkg::cosTable[j][k]);
            end
            expBlk[j*blkN+i] = sum;             // out[j][i]
         end
      end
   endtask

   task automatic fillRandom();
      for (int n = 0; n < words; n++)
      begin
         inBlk[n] = $urandom;                   // full 32-bit range
      end
   endtask

   // called on a falling edge, returns on the falling edge after the move
   task automatic sendWord(input dctPkg::dataT word);
      int waited;
      waited  = 0;
      inValid = 1'b1;
      inData  = word;
      while (!inReady && waited < waitLimit)
      begin
         @(negedge clk);
         waited++;
      end
      if (!inReady)
      begin
         timedOut("input stream");
      end
      else
      begin
         @(negedge clk);                        // word moved at the rising edge
      end
      inValid = 1'b0;
   endtask

   task automatic recvWord(input bit backPressure, input string name,
                           output dctPkg::dataT word);
      int waited;
      bit got;
      waited = 0;
      got    = 1'b0;
      word   = '0;
      while (!got && waited < waitLimit)
      begin
         outReady = backPressure ? 1'($urandom % 2) : 1'b1;
         checkFlag(1'b0, inReady, {name, " inReady before last output word"});
         if (outValid && outReady)
         begin
            word = outData;                     // stable until the next rising edge
            got  = 1'b1;
         end
         @(negedge clk);
         waited++;
      end
      outReady = 1'b0;
      if (!got)
      begin
         timedOut("output stream");
      end
   endtask

   // one whole block: load, wait out compute, unload and compare
   task automatic runBlock(input string name, input bit gaps, input bit backPressure);
      dctPkg::dataT word;
      if (aborted)
      begin
         return;
      end
      for (int n = 0; n < words && !aborted; n++)
      begin
         sendWord(inBlk[n]);
         if (gaps)
         begin
            repeat ($urandom % 4) @(negedge clk);   // idle cycles between words
         end
      end
      for (int n = 0; n < words && !aborted; n++)
      begin
         recvWord(backPressure, name, word);
         if (!aborted)
         begin
            checkData(expBlk[n], word, $sformatf("%s[%0d]", name, n));
         end
      end
      if (!aborted)
      begin
         checkFlag(1'b1, inReady, {name, " inReady after last word"});
         checkFlag(1'b0, outValid, {name, " outValid after last word"});
      end
   endtask

   initial
   begin
      int           seedDummy;
      dctPkg::dataT dcValue;
      inValid       = 1'b0;
      inData        = '0;
      outReady      = 1'b0;
      reset         = 1'b1;
      dataErrors    = 0;
      flagErrors    = 0;
      timeoutErrors = 0;
      aborted       = 1'b0;
      seedDummy     = $urandom(32'hbf1082ab);   // only seeding of the run
      repeat (16) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      checkFlag(1'b1, inReady, "reset inReady");
      checkFlag(1'b0, outValid, "reset outValid");

      fillRandom();
      runModel();
      runBlock("randomBlock", 1'b0, 1'b0);

      fillRandom();
      runModel();
      runBlock("inputGaps", 1'b1, 1'b0);

      fillRandom();
      runModel();
      runBlock("backPressure", 1'b0, 1'b1);

      // flat block, only the DC term survives: 91*8 = 728 per pass
      dcValue = $urandom;
      for (int n = 0; n < words; n++)
      begin
         inBlk[n]  = dcValue;
         expBlk[n] = '0;
      end
      expBlk[0] = dcValue * dctPkg::dataT'(728 * 728);
      runBlock("dcBlock", 1'b0, 1'b0);

      for (int b = 0; b < 3; b++)
      begin
         fillRandom();
         runModel();
         runBlock($sformatf("backToBack%0d", b), 1'($urandom % 2), 1'($urandom % 2));
      end

      $display("errors: data %0d, flag %0d, timeout %0d, assertion %0d",
               dataErrors, flagErrors, timeoutErrors, dctTop_inst.propsInst.failCount);
      if (dataErrors + flagErrors + timeoutErrors + dctTop_inst.propsInst.failCount == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- tb/dct_props.sv
`timescale 1ns/1ps

module dctProps
(
   input  logic         clk,
   input  logic         reset,
   input  logic         inReady,
   input  logic         outValid,
   input  logic         outReady,
   input  dctPkg::dataT outData
);

   int failCount;                      // read by the testbench at the end

   initial
   begin
      failCount = 0;
   end

   // a stalled output word must not move or change
   holdOnStall: assert property (@(posedge clk) disable iff (reset)
      (outValid && !outReady) |=> (outValid && $stable(outData)))
   else
   begin
      $error("output word changed or vanished under back-pressure");
      failCount++;
   end

   // load and unload never overlap
   noOverlap: assert property (@(posedge clk) disable iff (reset)
      !(inReady && outValid))
   else
   begin
      $error("inReady and outValid high in the same cycle");
      failCount++;
   end

   // first cycle out of reset shows no output word
   quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !outValid)
   else
   begin
      $error("outValid high right after reset");
      failCount++;
   end

endmodule

//--- verilog/dctBlockBuffer.sv
`timescale 1ns/1ps
`include "dct_cfg.svh"

module dctBlockBuffer
(
   input  logic         clk,
   input  logic         wrEn,       // write strobe
   input  dctPkg::addrT wrAddr,     // row-major write slot
   input  dctPkg::dataT wrData,
   input  dctPkg::addrT rdAddr,     // row-major read slot
   output dctPkg::dataT rdData      // valid one cycle after rdAddr
);

   // one full 8x8 block
   dctPkg::dataT mem [`DCT_BLOCK_N * `DCT_BLOCK_N];

   always_ff @(posedge clk)
   begin
      if (wrEn)
      begin
         mem[wrAddr] <= wrData;     // lands at this edge
      end
      rdData <= mem[rdAddr];        // registered read, old data on same-slot write
   end

endmodule

//--- verilog/dctMacUnit.sv
`timescale 1ns/1ps

module dctMacUnit
(
   input  logic         clk,
   input  logic         reset,
   input  logic         stepValid,     // one tap per cycle
   input  dctPkg::dataT sample,        // from buffer read data
   input  dctPkg::coefT coef,
   input  logic         tapLast,       // tap 7 closes the dot product
   input  dctPkg::addrT destAddr,      // where the finished sum goes
   output logic         resultValid,   // 2 cycles after the tapLast step
   output dctPkg::dataT result,
   output dctPkg::addrT resultAddr
);

   logic         prodValid;            // product stage occupied
   logic         prodLast;             // product stage holds tap 7
   logic         sumStart;             // next product opens a new sum
   dctPkg::dataT product;
   dctPkg::dataT acc;
   dctPkg::addrT prodAddr;

   // control side of the delay line
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         prodValid   <= 1'b0;
         prodLast    <= 1'b0;
         resultValid <= 1'b0;
         sumStart    <= 1'b1;          // first tap after reset starts clean
      end
      else
      begin
         prodValid   <= stepValid;
         prodLast    <= stepValid && tapLast;
         resultValid <= prodValid && prodLast;
         if (prodValid)
         begin
            sumStart <= prodLast;      // restart after the tap-7 step
         end
      end
   end

   // data side, product then accumulate
   always_ff @(posedge clk)
   begin
      product  <= sample * dctPkg::dataT'(coef);   // sign-extended, low 32 bits kept
      prodAddr <= destAddr;                        // rides beside the product
      if (prodValid)
      begin
         acc <= (sumStart ? dctPkg::dataT'(0) : acc) + product;   // wraps at 32
      end
      resultAddr <= prodAddr;          // arrives with the finished sum
   end

   assign result = acc;                // only meaningful with resultValid

endmodule

//--- verilog/dctPkg.sv
`include "dct_cfg.svh"

package dctPkg;

   // width of one index inside a pass step
   localparam int idxW = `DCT_STEP_W / 3;

   typedef logic signed [`DCT_DATA_W-1:0] dataT;   // sample / partial / result
   typedef logic signed [`DCT_COEF_W-1:0] coefT;   // cosine coefficient
   typedef logic [`DCT_ADDR_W-1:0] addrT;          // row-major buffer address

   // one pass step, counted flat but decoded as i, j, k
   typedef union packed
   {
      logic [`DCT_STEP_W-1:0] flat;                // plain incrementing count
      struct packed
      {
         logic [idxW-1:0] i;                       // outer, output column
         logic [idxW-1:0] j;                       // middle, output row
         logic [idxW-1:0] k;                       // tap, fastest
      } f;
   } stepIndexT;

   // C[u][x], row 0 is 91 = 128/sqrt(2), else round(128*cos((2x+1)u*pi/16))
   localparam coefT cosTable [`DCT_BLOCK_N][`DCT_BLOCK_N] = '{
      '{  91,   91,   91,   91,   91,   91,   91,   91},
      '{ 126,  106,   71,   25,  -25,  -71, -106, -126},
      '{ 118,   49,  -49, -118, -118,  -49,   49,  118},
      '{ 106,  -25, -126,  -71,   71,  126,   25, -106},
      '{  91,  -91,  -91,   91,   91,  -91,  -91,   91},
      '{  71, -126,   25,  106, -106,  -25,  126,  -71},
      '{  49, -118,  118,  -49,  -49,  118, -118,   49},
      '{  25,  -71,  106, -126,  126, -106,   71,  -25}
   };

endpackage

//--- verilog/dctSequencer.sv
`timescale 1ns/1ps

module dctSequencer
(
   input  logic         clk,
   input  logic         reset,
   // input stream
   input  logic         inValid,
   output logic         inReady,
   input  dctPkg::dataT inData,
   // output stream, data comes straight from bufA
   output logic         outValid,
   input  logic         outReady,
   // bufA, input block then results
   output logic         bufAWrEn,
   output dctPkg::addrT bufAWrAddr,
   output dctPkg::dataT bufAWrData,
   output dctPkg::addrT bufARdAddr,
   // bufB, row-pass intermediate
   output logic         bufBWrEn,
   output dctPkg::addrT bufBWrAddr,
   output dctPkg::addrT bufBRdAddr,
   // MAC step, aligned with buffer read data
   output logic         stepValid,
   output dctPkg::coefT coef,
   output logic         tapLast,
   output dctPkg::addrT destAddr,
   // MAC result
   input  logic         resultValid,
   input  dctPkg::dataT result,
   input  dctPkg::addrT resultAddr,
   // sample mux select, high while bufB feeds the MAC
   output logic         colPass
);

   localparam logic [2:0] stLoad     = 3'd0;   // accept 64 words
   localparam logic [2:0] stRow      = 3'd1;   // 512 steps, bufA -> bufB
   localparam logic [2:0] stRowDrain = 3'd2;   // wait for last row result
   localparam logic [2:0] stCol      = 3'd3;   // 512 steps, bufB -> bufA
   localparam logic [2:0] stColDrain = 3'd4;   // wait for last column result
   localparam logic [2:0] stUnload   = 3'd5;   // stream 64 results

   logic [2:0]        state;
   dctPkg::stepIndexT step;       // flat count, decoded as i/j/k
   dctPkg::addrT      loadCnt;    // next load slot
   dctPkg::addrT      rdPtr;      // next unload slot to read
   dctPkg::addrT      heldAddr;   // slot currently shown on outData
   logic              lastRead;   // word 64 already in the read register
   logic              inPass;     // issuing steps this cycle
   logic              rowPhase;   // row pass or its drain
   logic              loadFire;   // input word moves
   logic              unloadAdv;  // output register empty or being taken

   assign inPass    = (state == stRow) || (state == stCol);
   assign rowPhase  = (state == stRow) || (state == stRowDrain);
   assign colPass   = (state == stCol) || (state == stColDrain);
   assign inReady   = (state == stLoad);
   assign loadFire  = inReady && inValid;
   assign unloadAdv = (state == stUnload) && (!outValid || outReady);
   assign heldAddr  = rdPtr - dctPkg::addrT'(1);

   // bufA written by the input stream, later by column results
   assign bufAWrEn   = loadFire || (colPass && resultValid);
   assign bufAWrAddr = inReady ? loadCnt : resultAddr;
   assign bufAWrData = inReady ? inData : result;

   // row pass reads in[j][k], unload rereads the held slot on a stall
   always_comb
   begin
      if (state == stUnload)
      begin
         bufARdAddr = unloadAdv ? rdPtr : heldAddr;
      end
      else
      begin
         bufARdAddr = {step.f.j, step.f.k};
      end
   end

   // bufB takes row results, column pass reads temp[k][i]
   assign bufBWrEn   = rowPhase && resultValid;
   assign bufBWrAddr = resultAddr;
   assign bufBRdAddr = {step.f.k, step.f.i};

   // step payload, one cycle late to match the registered read
   always_ff @(posedge clk)
   begin
      if (colPass)
      begin
         coef <= dctPkg::cosTable[step.f.j][step.f.k];   // C[j][k]
      end
      else
      begin
         coef <= dctPkg::cosTable[step.f.i][step.f.k];   // C[i][k]
      end
      tapLast  <= &step.f.k;                             // tap 7
      destAddr <= {step.f.j, step.f.i};                  // result slot (j,i)
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state     <= stLoad;
         step      <= '0;
         loadCnt   <= '0;
         rdPtr     <= '0;
         lastRead  <= 1'b0;
         outValid  <= 1'b0;
         stepValid <= 1'b0;
      end
      else
      begin
         stepValid <= inPass;                            // tracks the address cycle
         case (state)
            stLoad:
            begin
               if (loadFire)
               begin
                  loadCnt <= loadCnt + dctPkg::addrT'(1);   // wraps back to 0
                  if (&loadCnt)
                  begin
                     state <= stRow;                     // 64th word moved
                  end
               end
            end
            stRow, stCol:
            begin
               step.flat <= step.flat + 1'b1;            // wraps to 0 after 511
               if (&step.flat)
               begin
                  state <= (state == stRow) ? stRowDrain : stColDrain;
               end
            end
            stRowDrain:
            begin
               // only the final sum is still in flight here
               if (resultValid)
               begin
                  state <= stCol;
               end
            end
            stColDrain:
            begin
               if (resultValid)
               begin
                  state <= stUnload;
               end
            end
            stUnload:
            begin
               if (unloadAdv)
               begin
                  if (lastRead)
                  begin
                     outValid <= 1'b0;                   // word 64 taken
                     lastRead <= 1'b0;
                     state    <= stLoad;
                  end
                  else
                  begin
                     outValid <= 1'b1;                   // read data valid next cycle
                     rdPtr    <= rdPtr + dctPkg::addrT'(1);
                     lastRead <= &rdPtr;
                  end
               end
            end
            default:
            begin
               state <= stLoad;
            end
         endcase
      end
   end

endmodule

//--- verilog/dctTop.sv
`timescale 1ns/1ps

module dctTop
(
   input  logic         clk,
   input  logic         reset,
   input  logic         inValid,
   output logic         inReady,
   input  dctPkg::dataT inData,
   output logic         outValid,
   input  logic         outReady,
   output dctPkg::dataT outData
);

   logic         bufAWrEn;
   dctPkg::addrT bufAWrAddr;
   dctPkg::dataT bufAWrData;
   dctPkg::addrT bufARdAddr;
   dctPkg::dataT bufARdData;
   logic         bufBWrEn;
   dctPkg::addrT bufBWrAddr;
   dctPkg::addrT bufBRdAddr;
   dctPkg::dataT bufBRdData;
   logic         stepValid;
   dctPkg::coefT coef;
   logic         tapLast;
   dctPkg::addrT destAddr;
   logic         resultValid;
   dctPkg::dataT result;
   dctPkg::addrT resultAddr;
   logic         colPass;       // bufB feeds the MAC
   dctPkg::dataT macSample;

   assign macSample = colPass ? bufBRdData : bufARdData;   // row pass reads bufA
   assign outData   = bufARdData;                           // results unload from bufA

   dctSequencer sequencer
   (
      .clk         (clk),
      .reset       (reset),
      .inValid     (inValid),
      .inReady     (inReady),
      .inData      (inData),
      .outValid    (outValid),
      .outReady    (outReady),
      .bufAWrEn    (bufAWrEn),
      .bufAWrAddr  (bufAWrAddr),
      .bufAWrData  (bufAWrData),
      .bufARdAddr  (bufARdAddr),
      .bufBWrEn    (bufBWrEn),
      .bufBWrAddr  (bufBWrAddr),
      .bufBRdAddr  (bufBRdAddr),
      .stepValid   (stepValid),
      .coef        (coef),
      .tapLast     (tapLast),
      .destAddr    (destAddr),
      .resultValid (resultValid),
      .result      (result),
      .resultAddr  (resultAddr),
      .colPass     (colPass)
   );

   // input block, then final results
   dctBlockBuffer bufA
   (
      .clk    (clk),
      .wrEn   (bufAWrEn),
      .wrAddr (bufAWrAddr),
      .wrData (bufAWrData),
      .rdAddr (bufARdAddr),
      .rdData (bufARdData)
   );

   // row-pass intermediate, written straight from the MAC
   dctBlockBuffer bufB
   (
      .clk    (clk),
      .wrEn   (bufBWrEn),
      .wrAddr (bufBWrAddr),
      .wrData (result),
      .rdAddr (bufBRdAddr),
      .rdData (bufBRdData)
   );

   dctMacUnit mac
   (
      .clk         (clk),
      .reset       (reset),
      .stepValid   (stepValid),
      .sample      (macSample),
      .coef        (coef),
      .tapLast     (tapLast),
      .destAddr    (destAddr),
      .resultValid (resultValid),
      .result      (result),
      .resultAddr  (resultAddr)
   );

endmodule

//--- verilog/dct_cfg.svh
`ifndef DCT_CFG_SVH
`define DCT_CFG_SVH

// sample, intermediate and result width
`define DCT_DATA_W 32

// signed cosine coefficient width
`define DCT_COEF_W 8

// block side, 8x8 samples per block
`define DCT_BLOCK_N 8

// buffer address width, log2 of 64 words
`define DCT_ADDR_W 6

// pass step counter, three 3-bit indices i, j, k
`define DCT_STEP_W 9

`endif
